/* src/stepper_pkg.sv */
/*
  Shared definitions for the stepper controller SPI control path.
  Holds the memory map, the SPI and RAM sizes and the packed structs
  that carry the CPU bus and the SPI command and result between blocks.
*/

package stepper_pkg;

  // memory map, byte addresses
  localparam logic [31:0] ram_base     = 32'h0000_1000;
  localparam logic [31:0] ram_limit    = 32'h0000_2000;
  localparam logic [31:0] reg_tx_upper = 32'h1000_0000;
  localparam logic [31:0] reg_tx_lower = 32'h1000_0004;
  localparam logic [31:0] reg_rx_upper = 32'h1000_0008;
  localparam logic [31:0] reg_rx_lower = 32'h1000_000c;
  localparam logic [31:0] reg_config   = 32'h1000_0010;
  localparam logic [31:0] reg_status   = 32'h1000_0014;

  localparam int ram_words  = 1024;
  localparam int ram_addr_w = $clog2(ram_words);

  // spi framing
  localparam int spi_bits        = 40;
  localparam int spi_half_period = 8;
  localparam int spi_div_w       = $clog2(spi_half_period);
  localparam int spi_cnt_w       = $clog2(spi_bits + 1);
  localparam int cs_count        = 12;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } bus_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } bus_rsp_t;

  // one-hot target of the access in flight
  typedef struct packed {
    logic ram;
    logic tx_upper;
    logic tx_lower;
    logic rx_upper;
    logic rx_lower;
    logic cfg;
    logic status;
    logic none;
  } bus_sel_t;

  typedef struct packed {
    logic                start;
    logic [3:0]          cs_sel;
    logic [spi_bits-1:0] tx_data;
  } spi_cmd_t;

  typedef struct packed {
    logic                busy;
    logic                done;
    logic [spi_bits-1:0] rx_data;
  } spi_result_t;

endpackage

/* src/bus_fabric.sv */
/*
  Memory map decoder for the CPU bus.
  Accepts one request at a time, registers a one-hot select for the
  addressed block, then answers with a single ready cycle and the
  read word of that block. Unmapped accesses get ready with zero data.
*/

`timescale 1ns/1ns

module bus_fabric import stepper_pkg::*; (
  input  logic     clk_25mhz,
  input  logic     reset,
  input  bus_req_t bus_req,
  output bus_rsp_t bus_rsp,
  output bus_sel_t sel,
  input  logic [31:0] ram_rdata,
  input  logic [31:0] reg_rdata,
  output logic     unmapped
);

  typedef enum logic [1:0] {
    st_idle,
    st_select,
    st_respond
  } fabric_state_t;

  fabric_state_t state;
  bus_sel_t      decode;
  bus_sel_t      rsp_sel;
  logic          ready_q;

  // address compare against the package map
  always_comb begin
    decode = '0;
    if (bus_req.addr >= ram_base && bus_req.addr < ram_limit) begin
      decode.ram = 1'b1;
    end else begin
      case (bus_req.addr)
        reg_tx_upper: decode.tx_upper = 1'b1;
        reg_tx_lower: decode.tx_lower = 1'b1;
        reg_rx_upper: decode.rx_upper = 1'b1;
        reg_rx_lower: decode.rx_lower = 1'b1;
        reg_config:   decode.cfg      = 1'b1;
        reg_status:   decode.status   = 1'b1;
        default:      decode.none     = 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk_25mhz) begin
    if (reset) begin
      state    <= st_idle;
      sel      <= '0;
      rsp_sel  <= '0;
      ready_q  <= 1'b0;
      unmapped <= 1'b0;
    end else begin
      sel     <= '0;
      rsp_sel <= sel;
      ready_q <= (state == st_select);
      case (state)
        st_idle: begin
          if (bus_req.valid) begin
            sel      <= decode;
            unmapped <= decode.none;
            state    <= st_select;
          end
        end
        st_select:  state <= st_respond;
        // valid is still the old request here, skip it
        st_respond: state <= st_idle;
        default:    state <= st_idle;
      endcase
    end
  end

  always_comb begin
    bus_rsp.ready = ready_q;
    bus_rsp.rdata = '0;
    if (rsp_sel.ram) begin
      bus_rsp.rdata = ram_rdata;
    end else if (rsp_sel != '0 && !rsp_sel.none) begin
      bus_rsp.rdata = reg_rdata;
    end
  end

endmodule

/* src/word_ram.sv */
/*
  Word RAM behind the CPU bus.
  Reads or writes one 32-bit word in the select cycle, writing only the
  bytes whose strobe is set. The read word is valid in the ready cycle.
*/

`timescale 1ns/1ns

module word_ram import stepper_pkg::*; (
  input  logic        clk_25mhz,
  input  bus_sel_t    sel,
  input  bus_req_t    req,
  output logic [31:0] rdata
);

  logic [31:0]           mem [ram_words];
  logic [ram_addr_w-1:0] index;

  // byte address to word index inside the window
  assign index = req.addr[ram_addr_w+1:2];

  always_ff @(posedge clk_25mhz) begin
    if (sel.ram) begin
      for (int b = 0; b < 4; b++) begin
        if (req.wstrb[b]) begin
          mem[index][8*b +: 8] <= req.wdata[8*b +: 8];
        end
      end
      rdata <= mem[index];
    end
  end

endmodule

/* src/spi_regs.sv */
/*
  SPI register block on the CPU bus.
  Stores the outgoing 40-bit word and the chip-select number, issues a
  one-cycle start on a config write with bit 0 set, and captures the
  received word when the SPI master reports done.
*/

`timescale 1ns/1ns

module spi_regs import stepper_pkg::*; (
  input  logic        clk_25mhz,
  input  logic        reset,
  input  bus_sel_t    sel,
  input  bus_req_t    req,
  output logic [31:0] rdata,
  output spi_cmd_t    spi_cmd,
  input  spi_result_t spi_res
);

  logic [31:0] tx_upper;
  logic [31:0] tx_lower;
  logic [3:0]  cs_sel;
  logic        start;
  logic [7:0]  rx_upper;
  logic [31:0] rx_lower;
  logic        write_en;
  logic [31:0] read_word;

  // registers take the whole word on any strobe
  assign write_en = |req.wstrb;

  always_ff @(posedge clk_25mhz) begin
    if (reset) begin
      tx_upper <= '0;
      tx_lower <= '0;
      cs_sel   <= '0;
      start    <= 1'b0;
      rx_upper <= '0;
      rx_lower <= '0;
    end else begin
      start <= 1'b0;
      if (write_en) begin
        if (sel.tx_upper) begin
          tx_upper <= req.wdata;
        end
        if (sel.tx_lower) begin
          tx_lower <= req.wdata;
        end
        if (sel.cfg) begin
          cs_sel <= req.wdata[4:1];
          start  <= req.wdata[0];
        end
      end
      if (spi_res.done) begin
        rx_upper <= spi_res.rx_data[spi_bits-1:32];
        rx_lower <= spi_res.rx_data[31:0];
      end
    end
  end

  always_comb begin
    read_word = '0;
    if (sel.tx_upper) begin
      read_word = tx_upper;
    end
    if (sel.tx_lower) begin
      read_word = tx_lower;
    end
    if (sel.rx_upper) begin
      read_word = {24'b0, rx_upper};
    end
    if (sel.rx_lower) begin
      read_word = rx_lower;
    end
    // start bit is a strobe and reads back as zero
    if (sel.cfg) begin
      read_word = {27'b0, cs_sel, 1'b0};
    end
    // bit 0 set while a transfer runs
    if (sel.status) begin
      read_word = {31'b0, spi_res.busy};
    end
  end

  always_ff @(posedge clk_25mhz) begin
    rdata <= read_word;
  end

  assign spi_cmd.start   = start;
  assign spi_cmd.cs_sel  = cs_sel;
  assign spi_cmd.tx_data = {tx_upper[7:0], tx_lower};

endmodule

/* src/spi_master.sv */
/*
  40-bit SPI master, mode 3, MSB first.
  A start while idle latches the word and chip select, then SCK runs at
  spi_half_period clocks per half period. MOSI changes on falling edges,
  MISO is sampled on rising edges, and done pulses when cs_n returns high.
*/

`timescale 1ns/1ns

module spi_master import stepper_pkg::*; (
  input  logic                clk_25mhz,
  input  logic                reset,
  input  spi_cmd_t            spi_cmd,
  output spi_result_t         spi_res,
  input  logic                miso,
  output logic                sck,
  output logic                mosi,
  output logic [cs_count-1:0] cs_n
);

  logic                 busy;
  logic                 done;
  logic [3:0]           cs_q;
  logic [spi_div_w-1:0] div_cnt;
  logic [spi_cnt_w-1:0] rise_cnt;
  logic [spi_bits-1:0]  tx_shift;
  logic [spi_bits-1:0]  rx_shift;
  logic                 tick;

  // end of one sck half period
  assign tick = busy && (div_cnt == spi_half_period - 1);

  always_ff @(posedge clk_25mhz) begin
    if (reset) begin
      busy     <= 1'b0;
      done     <= 1'b0;
      cs_q     <= '0;
      div_cnt  <= '0;
      rise_cnt <= '0;
      sck      <= 1'b1;
      mosi     <= 1'b0;
    end else begin
      done <= 1'b0;
      if (!busy) begin
        if (spi_cmd.start) begin
          busy     <= 1'b1;
          cs_q     <= spi_cmd.cs_sel;
          div_cnt  <= '0;
          rise_cnt <= '0;
          mosi     <= spi_cmd.tx_data[spi_bits-1];
        end
      end else begin
        if (tick) begin
          div_cnt <= '0;
        end else begin
          div_cnt <= div_cnt + 1'b1;
        end
        if (tick) begin
          if (rise_cnt == spi_bits) begin
            // trailing half period done, release the chip select
            busy <= 1'b0;
            done <= 1'b1;
            mosi <= 1'b0;
          end else if (sck) begin
            sck <= 1'b0;
            // first falling edge keeps bit 39 on the line
            if (rise_cnt != 0) begin
              mosi <= tx_shift[spi_bits-2];
            end
          end else begin
            sck      <= 1'b1;
            rise_cnt <= rise_cnt + 1'b1;
          end
        end
      end
    end
  end

  // shift registers carry payload only
  always_ff @(posedge clk_25mhz) begin
    if (!busy && spi_cmd.start) begin
      tx_shift <= spi_cmd.tx_data;
    end else if (tick && sck && rise_cnt != 0 && rise_cnt != spi_bits) begin
      tx_shift <= {tx_shift[spi_bits-2:0], 1'b0};
    end
    if (tick && !sck && rise_cnt != spi_bits) begin
      rx_shift <= {rx_shift[spi_bits-2:0], miso};
    end
  end

  // out-of-range numbers run the transfer with no device selected
  always_comb begin
    cs_n = '1;
    if (busy && cs_q < cs_count) begin
      cs_n[cs_q] = 1'b0;
    end
  end

  assign spi_res.busy    = busy;
  assign spi_res.done    = done;
  assign spi_res.rx_data = rx_shift;

endmodule

/* src/stepper_top.sv */
/*
  Top level of the SPI control path.
  The CPU bus enters here and reaches the word RAM and the SPI register
  block through the fabric. The register block steers the SPI master,
  whose pins go straight out to the driver chips.
*/

`timescale 1ns/1ns

module stepper_top import stepper_pkg::*; (
  input  logic                clk_25mhz,
  input  logic                reset,
  input  bus_req_t            bus_req,
  output bus_rsp_t            bus_rsp,
  input  logic                miso,
  output logic                sck,
  output logic                mosi,
  output logic [cs_count-1:0] cs_n,
  output logic [7:0]          led
);

  bus_sel_t    sel;
  logic [31:0] ram_rdata;
  logic [31:0] reg_rdata;
  logic        unmapped;
  spi_cmd_t    spi_cmd;
  spi_result_t spi_res;

  bus_fabric u_fabric (
    .clk_25mhz (clk_25mhz),
    .reset     (reset),
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp),
    .sel       (sel),
    .ram_rdata (ram_rdata),
    .reg_rdata (reg_rdata),
    .unmapped  (unmapped)
  );

  word_ram u_ram (
    .clk_25mhz (clk_25mhz),
    .sel       (sel),
    .req       (bus_req),
    .rdata     (ram_rdata)
  );

  spi_regs u_regs (
    .clk_25mhz (clk_25mhz),
    .reset     (reset),
    .sel       (sel),
    .req       (bus_req),
    .rdata     (reg_rdata),
    .spi_cmd   (spi_cmd),
    .spi_res   (spi_res)
  );

  spi_master u_spi (
    .clk_25mhz (clk_25mhz),
    .reset     (reset),
    .spi_cmd   (spi_cmd),
    .spi_res   (spi_res),
    .miso      (miso),
    .sck       (sck),
    .mosi      (mosi),
    .cs_n      (cs_n)
  );

  // debug leds
  assign led = {unmapped, 2'b00, spi_cmd.cs_sel, spi_res.busy};

endmodule

/* dv/stepper_props.sv */
/*
  Concurrent checks on the stepper controller top level.
  Bound into stepper_top; covers bus ready timing, chip-select exclusivity
  and the SCK edge count of each SPI frame.
*/

`timescale 1ns/1ns

module stepper_props import stepper_pkg::*; (
  input logic                clk_25mhz,
  input logic                reset,
  input bus_req_t            bus_req,
  input bus_rsp_t            bus_rsp,
  input logic                sck,
  input logic [cs_count-1:0] cs_n,
  input logic [7:0]          led
);

  int         prop_errors = 0;
  logic       in_flight;
  logic       accept;
  logic       busy;
  logic       any_cs;
  logic       sck_q;
  logic [7:0] rise_cnt;

  assign accept = bus_req.valid && !in_flight;
  assign busy   = led[0];
  assign any_cs = !(&cs_n);

  // access open from acceptance until ready is seen
  always_ff @(posedge clk_25mhz) begin
    if (reset) begin
      in_flight <= 1'b0;
    end else if (accept) begin
      in_flight <= 1'b1;
    end else if (bus_rsp.ready) begin
      in_flight <= 1'b0;
    end
  end

  // rising sck edges inside one low chip-select period
  always_ff @(posedge clk_25mhz) begin
    if (reset) begin
      sck_q    <= 1'b1;
      rise_cnt <= '0;
    end else begin
      sck_q <= sck;
      if (!any_cs) begin
        rise_cnt <= '0;
      end else if (sck && !sck_q) begin
        rise_cnt <= rise_cnt + 1'b1;
      end
    end
  end

  a_ready_latency: assert property (@(posedge clk_25mhz) disable iff (reset)
    accept |=> !bus_rsp.ready ##1 bus_rsp.ready ##1 !bus_rsp.ready)
    else begin
      $error("ready not exactly two cycles after acceptance");
      prop_errors++;
    end

  a_ready_cause: assert property (@(posedge clk_25mhz) disable iff (reset)
    bus_rsp.ready |-> $past(accept, 2))
    else begin
      $error("ready without an accepted request");
      prop_errors++;
    end

  a_one_cs: assert property (@(posedge clk_25mhz) disable iff (reset)
    $countones(~cs_n) <= 1)
    else begin
      $error("more than one chip select low");
      prop_errors++;
    end

  a_cs_stable: assert property (@(posedge clk_25mhz) disable iff (reset)
    busy && $past(busy) |-> $stable(cs_n))
    else begin
      $error("chip select changed during a transfer");
      prop_errors++;
    end

  a_sck_count: assert property (@(posedge clk_25mhz) disable iff (reset)
    $fell(any_cs) |-> rise_cnt == spi_bits)
    else begin
      $error("wrong number of sck rising edges in a frame");
      prop_errors++;
    end

endmodule

bind stepper_top stepper_props u_props (
  .clk_25mhz (clk_25mhz),
  .reset     (reset),
  .bus_req   (bus_req),
  .bus_rsp   (bus_rsp),
  .sck       (sck),
  .cs_n      (cs_n),
  .led       (led)
);

/* dv/tb_stepper.sv */
/*
  Testbench for the stepper controller SPI control path.
  Drives the CPU bus in place of the soft CPU, models one SPI driver chip
  on chip select 5, and checks RAM, register and SPI behavior by readback.
*/

`timescale 1ns/1ns

module tb_stepper import stepper_pkg::*; ();

  logic                clk_25mhz;
  logic                reset;
  bus_req_t            bus_req;
  bus_rsp_t            bus_rsp;
  logic                miso;
  logic                sck;
  logic                mosi;
  logic [cs_count-1:0] cs_n;
  logic [7:0]          led;

  int          errors = 0;
  int          cycles = 0;
  int          cycle_limit = 6000;
  logic [39:0] slave_resp = '0;
  logic [39:0] slave_shift = '0;
  logic [39:0] mosi_cap = '0;
  logic [31:0] ram_model [int];

  stepper_top u_dut (
    .clk_25mhz (clk_25mhz),
    .reset     (reset),
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp),
    .miso      (miso),
    .sck       (sck),
    .mosi      (mosi),
    .cs_n      (cs_n),
    .led       (led)
  );

  initial begin
    clk_25mhz = 1'b0;
    forever #20 clk_25mhz = ~clk_25mhz;
  end

  always @(posedge clk_25mhz) cycles <= cycles + 1;

  initial begin
    wait (cycles >= cycle_limit);
    $display("timeout: run stopped after %0d cycles", cycles);
    $display("Verification failed");
    $finish;
  end

  // driver chip on cs 5 shifts its response out on falling sck
  always @(negedge cs_n[5]) begin
    slave_shift = slave_resp;
    mosi_cap = '0;
  end

  always @(negedge sck) begin
    if (!cs_n[5]) begin
      #5;
      miso = slave_shift[39];
      slave_shift = {slave_shift[38:0], 1'b0};
    end
  end

  // line floats high when the chip is released
  always @(posedge cs_n[5]) begin
    #5;
    miso = 1'b1;
  end

  always @(posedge sck) begin
    if (!cs_n[5]) begin
      mosi_cap = {mosi_cap[38:0], mosi};
    end
  end

  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata);
    @(posedge clk_25mhz);
    #5;
    bus_req.valid = 1'b1;
    bus_req.addr  = addr;
    bus_req.wdata = wdata;
    bus_req.wstrb = wstrb;
    @(posedge clk_25mhz);
    #5;
    while (!bus_rsp.ready) begin
      @(posedge clk_25mhz);
      #5;
    end
    rdata   = bus_rsp.rdata;
    bus_req = '0;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] wstrb);
    logic [31:0] unused;
    bus_access(addr, wdata, wstrb, unused);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
    bus_access(addr, 32'h0, 4'h0, rdata);
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0] strb);
    logic [31:0] merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) merged[8*b +: 8] = new_word[8*b +: 8];
    end
    return merged;
  endfunction

  task automatic wait_spi_idle();
    logic [31:0] status;
    bus_read(reg_status, status);
    while (status[0]) bus_read(reg_status, status);
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] wd;
    logic [31:0] txu;
    logic [31:0] txl;
    logic [31:0] rnd;
    logic [3:0]  strb;
    int          idx;
    int          idx_list[$];

    void'($urandom(32'h4113_65a2));
    reset   = 1'b1;
    bus_req = '0;
    miso    = 1'b1;
    repeat (16) @(posedge clk_25mhz);
    #5;
    reset = 1'b0;

    // idle state after reset
    compare_value("cs_n", cs_n, 32'h0000_0fff);
    compare_value("sck", sck, 32'h1);
    compare_value("led", led, 32'h0);
    bus_read(reg_status, rd);
    compare_value("status", rd, 32'h0);

    // full words before partial strobes on top
    repeat (8) begin
      idx = $urandom_range(ram_words - 1, 0);
      wd  = $urandom;
      bus_write(ram_base + idx * 4, wd, 4'hf);
      ram_model[idx] = wd;
      idx_list.push_back(idx);
    end
    foreach (idx_list[i]) begin
      wd   = $urandom;
      strb = $urandom_range(15, 1);
      bus_write(ram_base + idx_list[i] * 4, wd, strb);
      ram_model[idx_list[i]] = merge_bytes(ram_model[idx_list[i]], wd, strb);
    end
    foreach (idx_list[i]) begin
      bus_read(ram_base + idx_list[i] * 4, rd);
      compare_value("ram rdata", rd, ram_model[idx_list[i]]);
    end

    // register readback with cs 5 and no start
    txu = $urandom;
    txl = $urandom;
    bus_write(reg_tx_upper, txu, 4'hf);
    bus_write(reg_tx_lower, txl, 4'h1);
    bus_write(reg_config, 32'h0000_000a, 4'h2);
    bus_read(reg_tx_upper, rd);
    compare_value("tx_upper", rd, txu);
    bus_read(reg_tx_lower, rd);
    compare_value("tx_lower", rd, txl);
    bus_read(reg_config, rd);
    compare_value("config", rd, 32'h0000_000a);
    bus_write(reg_status, 32'hffff_ffff, 4'hf);
    bus_read(reg_status, rd);
    compare_value("status after write", rd, 32'h0);
    bus_read(32'h2000_0000, rd);
    compare_value("unmapped rdata", rd, 32'h0);
    compare_value("led[7]", led[7], 32'h1);

    // transfer on cs 5 with a second start while busy
    rnd        = $urandom;
    slave_resp = {rnd[7:0], $urandom};
    bus_write(reg_config, 32'h0000_000b, 4'hf);
    bus_read(reg_status, rd);
    compare_value("status busy", rd, 32'h1);
    compare_value("cs_n busy", cs_n, 32'h0000_0fdf);
    // busy in bit 0, cs 5 in bits 4:1, last access mapped
    compare_value("led busy", led, 32'h0000_000b);
    bus_write(reg_config, 32'h0000_000f, 4'hf);
    wait_spi_idle();
    compare_value("mosi[39:32]", mosi_cap[39:32], txu[7:0]);
    compare_value("mosi[31:0]", mosi_cap[31:0], txl);
    compare_value("cs_n idle", cs_n, 32'h0000_0fff);
    bus_read(reg_rx_upper, rd);
    compare_value("rx_upper", rd, {24'h0, slave_resp[39:32]});
    bus_read(reg_rx_lower, rd);
    compare_value("rx_lower", rd, slave_resp[31:0]);
    bus_read(reg_config, rd);
    compare_value("config after restart", rd, 32'h0000_000e);

    // cs 13 selects nothing so miso stays high
    bus_write(reg_config, 32'h0000_001b, 4'hf);
    bus_read(reg_status, rd);
    compare_value("status busy", rd, 32'h1);
    compare_value("cs_n no device", cs_n, 32'h0000_0fff);
    wait_spi_idle();
    bus_read(reg_rx_upper, rd);
    compare_value("rx_upper", rd, 32'h0000_00ff);
    bus_read(reg_rx_lower, rd);
    compare_value("rx_lower", rd, 32'hffff_ffff);

    $display("run complete: %0d compare errors, %0d assertion errors",
             errors, u_dut.u_props.prop_errors);
    if (errors == 0 && u_dut.u_props.prop_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
src/stepper_pkg.sv
src/bus_fabric.sv
src/word_ram.sv
src/spi_regs.sv
src/spi_master.sv
src/stepper_top.sv
dv/stepper_props.sv
dv/tb_stepper.sv
